// File: logic/tile_video_pkg.sv
`default_nettype none

package tile_video_pkg;

	////////////////////////////////////////
	// pixel chain types
	////////////////////////////////////////

	// one pixel as it travels along the daisy chain
	typedef struct packed {
		logic [2:0] prio;
		logic [7:0] color;
		logic [2:0] dot;
	} pixel_t;

	// layer pixel before the mixer adds a priority
	typedef struct packed {
		logic [7:0] color;
		logic [2:0] dot;
	} layer_pix_t;

	////////////////////////////////////////
	// fetch types
	////////////////////////////////////////

	// gdi layout with plane0 in the low nibble
	typedef struct packed {
		logic [3:0] plane2;
		logic [3:0] plane1;
		logic [3:0] plane0;
	} plane_set_t;

	// contents of one holding slot
	typedef struct packed {
		logic [7:0] attr;
		plane_set_t planes;
	} tile_fetch_t;

	// mdi carries either a fetched attribute or a cpu priority write
	typedef union packed {
		logic [7:0] attr;
		struct packed {
			logic [3:0] spare_hi;
			logic [2:0] prio;
			logic       spare_lo;
		} prio_w;
	} mdi_word_u;

endpackage

`default_nettype wire

// File: logic/tile_regs_pkg.sv
`default_nettype none

package tile_regs_pkg;

	// cpu address bus width
	typedef logic [2:0] reg_addr_t;

	// priority register addresses
	localparam reg_addr_t ADDR_PRIO_A = 3'd1;
	localparam reg_addr_t ADDR_PRIO_B = 3'd5;

	// both layer priorities
	typedef struct packed {
		logic [2:0] prio_a;
		logic [2:0] prio_b;
	} prio_regs_t;

	// values after reset
	// B starts above A so B wins overlaps at power up
	localparam logic [2:0] PRIO_A_RESET = 3'd0;
	localparam logic [2:0] PRIO_B_RESET = 3'd1;

endpackage

`default_nettype wire

// File: logic/tile_fetch_latch.sv
`default_nettype none

module tile_fetch_latch (
	input  wire                       CLK_6M,
	input  wire                       layer,
	input  wire                       fetch_phase,
	input  wire [11:0]                gdi,
	input  tile_video_pkg::mdi_word_u mdi,
	output tile_video_pkg::tile_fetch_t slot_a,
	output tile_video_pkg::tile_fetch_t slot_b
);

	////////////////////////////////////////
	// phase tracking
	////////////////////////////////////////

	// copy of fetch_phase from the previous cycle
	logic phase_q;
	logic phase_change;

	// any toggle marks a completed fetch
	assign phase_change = fetch_phase != phase_q;

	always_ff @(posedge CLK_6M or negedge layer) begin
		if (!layer) begin
			phase_q <= 1'b0;
		end else begin
			phase_q <= fetch_phase;
		end
	end

	////////////////////////////////////////
	// holding slots
	////////////////////////////////////////

	// new phase level picks the slot
	// high means layer A was fetched, low means layer B
	tile_video_pkg::tile_fetch_t fetch_word;

	assign fetch_word.attr   = mdi.attr;
	assign fetch_word.planes = tile_video_pkg::plane_set_t'(gdi);

	always_ff @(posedge CLK_6M or negedge layer) begin
		if (!layer) begin
			slot_a <= '0;
			slot_b <= '0;
		end else if (phase_change) begin
			if (fetch_phase) begin
				slot_a <= fetch_word;
			end else begin
				slot_b <= fetch_word;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/tile_plane_shifter.sv
`default_nettype none

module tile_plane_shifter (
	input  wire                         CLK_6M,
	input  wire                         layer,
	input  wire                         load,
	input  tile_video_pkg::tile_fetch_t slot,
	output tile_video_pkg::layer_pix_t  pix
);

	////////////////////////////////////////
	// attribute hold and plane shift
	////////////////////////////////////////

	// attr holds across all four dots of a fetch
	logic [7:0]                 attr_q;
	tile_video_pkg::plane_set_t planes_q;

	always_ff @(posedge CLK_6M or negedge layer) begin
		if (!layer) begin
			attr_q   <= '0;
			planes_q <= '0;
		end else if (load) begin
			attr_q   <= slot.attr;
			planes_q <= slot.planes;
		end else begin
			// msb first, zeros fill in from the right
			planes_q.plane2 <= {planes_q.plane2[2:0], 1'b0};
			planes_q.plane1 <= {planes_q.plane1[2:0], 1'b0};
			planes_q.plane0 <= {planes_q.plane0[2:0], 1'b0};
		end
	end

	////////////////////////////////////////
	// layer pixel
	////////////////////////////////////////

	// dot is the top bit of every plane
	assign pix.color = attr_q;
	assign pix.dot   = {planes_q.plane2[3], planes_q.plane1[3], planes_q.plane0[3]};

endmodule

`default_nettype wire

// File: logic/tile_layer_mixer.sv
`default_nettype none

module tile_layer_mixer (
	input  wire                         CLK_6M,
	input  wire                         layer,
	input  wire                         prio_we,
	input  tile_regs_pkg::reg_addr_t    ca,
	input  tile_video_pkg::mdi_word_u   mdi,
	input  tile_video_pkg::layer_pix_t  layer_a,
	input  tile_video_pkg::layer_pix_t  layer_b,
	input  tile_video_pkg::pixel_t      pix_in,
	output tile_video_pkg::pixel_t      pix_out
);

	////////////////////////////////////////
	// cpu priority registers
	////////////////////////////////////////

	tile_regs_pkg::prio_regs_t prio_q;

	// only the two priority addresses respond
	always_ff @(posedge CLK_6M or negedge layer) begin
		if (!layer) begin
			prio_q.prio_a <= tile_regs_pkg::PRIO_A_RESET;
			prio_q.prio_b <= tile_regs_pkg::PRIO_B_RESET;
		end else if (prio_we) begin
			case (ca)
				tile_regs_pkg::ADDR_PRIO_A: prio_q.prio_a <= mdi.prio_w.prio;
				tile_regs_pkg::ADDR_PRIO_B: prio_q.prio_b <= mdi.prio_w.prio;
				default: prio_q <= prio_q;
			endcase
		end
	end

	////////////////////////////////////////
	// layer selection
	////////////////////////////////////////

	// dot zero is transparent
	logic a_opaque;
	logic b_opaque;
	logic b_above;

	// full chain pixels for each layer
	tile_video_pkg::pixel_t pix_a;
	tile_video_pkg::pixel_t pix_b;
	tile_video_pkg::pixel_t pix_sel;

	assign a_opaque = layer_a.dot != 3'd0;
	assign b_opaque = layer_b.dot != 3'd0;

	// ties go to A
	assign b_above = prio_q.prio_b > prio_q.prio_a;

	assign pix_a = '{prio: prio_q.prio_a, color: layer_a.color, dot: layer_a.dot};
	assign pix_b = '{prio: prio_q.prio_b, color: layer_b.color, dot: layer_b.dot};

	always_comb begin
		pix_sel = pix_in;
		if (a_opaque && b_opaque) begin
			pix_sel = b_above ? pix_b : pix_a;
		end else if (a_opaque) begin
			pix_sel = pix_a;
		end else if (b_opaque) begin
			pix_sel = pix_b;
		end
	end

	// one cycle behind the shifters
	always_ff @(posedge CLK_6M or negedge layer) begin
		if (!layer) begin
			pix_out <= '0;
		end else begin
			pix_out <= pix_sel;
		end
	end

endmodule

`default_nettype wire

// File: logic/tile_layer_gen.sv
`default_nettype none

module tile_layer_gen (
	input  wire                       CLK_6M,
	input  wire                       layer,
	input  wire                       fetch_phase,
	input  wire [11:0]                gdi,
	input  tile_video_pkg::mdi_word_u mdi,
	input  wire                       load_a,
	input  wire                       load_b,
	input  wire                       prio_we,
	input  tile_regs_pkg::reg_addr_t  ca,
	input  tile_video_pkg::pixel_t    pix_in,
	output tile_video_pkg::pixel_t    pix_out
);

	// holding slots from the fetch side
	tile_video_pkg::tile_fetch_t slot_a;
	tile_video_pkg::tile_fetch_t slot_b;

	// shifter outputs into the mixer
	tile_video_pkg::layer_pix_t layer_a;
	tile_video_pkg::layer_pix_t layer_b;

	////////////////////////////////////////
	// input side
	////////////////////////////////////////

	tile_fetch_latch fetch (
		.CLK_6M      (CLK_6M),
		.layer       (layer),
		.fetch_phase (fetch_phase),
		.gdi         (gdi),
		.mdi         (mdi),
		.slot_a      (slot_a),
		.slot_b      (slot_b)
	);

	////////////////////////////////////////
	// per layer shifters
	////////////////////////////////////////

	tile_plane_shifter shift_a (
		.CLK_6M (CLK_6M),
		.layer  (layer),
		.load   (load_a),
		.slot   (slot_a),
		.pix    (layer_a)
	);

	tile_plane_shifter shift_b (
		.CLK_6M (CLK_6M),
		.layer  (layer),
		.load   (load_b),
		.slot   (slot_b),
		.pix    (layer_b)
	);

	// priority mix against the upstream chip
	tile_layer_mixer mixer (
		.CLK_6M  (CLK_6M),
		.layer   (layer),
		.prio_we (prio_we),
		.ca      (ca),
		.mdi     (mdi),
		.layer_a (layer_a),
		.layer_b (layer_b),
		.pix_in  (pix_in),
		.pix_out (pix_out)
	);

endmodule

`default_nettype wire

// File: test/tile_layer_model.sv
`default_nettype none

module tile_layer_model (
	input  wire         CLK_6M,
	input  wire         layer,
	input  wire         fetch_phase,
	input  wire  [11:0] gdi,
	input  wire  [7:0]  mdi,
	input  wire         load_a,
	input  wire         load_b,
	input  wire         prio_we,
	input  wire  [2:0]  ca,
	input  wire  [13:0] pix_in,
	output logic [13:0] exp_pix
);

	timeunit 1ns;
	timeprecision 1ps;

	// index 0 is layer A, index 1 is layer B
	logic [7:0]  slot_attr [2];
	logic [11:0] slot_gfx  [2];
	logic [7:0]  sh_attr   [2];
	logic [11:0] sh_gfx    [2];
	logic [2:0]  prio      [2];
	logic        phase_seen;

	// top bit of each nibble, plane2 first
	function automatic logic [2:0] dot_of(input logic [11:0] gfx);
		return {gfx[11], gfx[7], gfx[3]};
	endfunction

	////////////////////////////////////////
	// one step per clock edge
	////////////////////////////////////////

	always @(posedge CLK_6M or negedge layer) begin : model_step
		logic [2:0] dot  [2];
		logic       load [2];
		if (!layer) begin
			for (int i = 0; i < 2; i++) begin
				slot_attr[i] = '0;
				slot_gfx[i]  = '0;
				sh_attr[i]   = '0;
				sh_gfx[i]    = '0;
			end
			prio[0]    = 3'd0;
			prio[1]    = 3'd1;
			phase_seen = 1'b0;
			exp_pix   <= '0;
		end else begin
			dot[0] = dot_of(sh_gfx[0]);
			dot[1] = dot_of(sh_gfx[1]);
			// A keeps ties, B needs a strictly higher priority
			if (dot[0] != 3'd0 && (dot[1] == 3'd0 || prio[0] >= prio[1])) begin
				exp_pix <= {prio[0], sh_attr[0], dot[0]};
			end else if (dot[1] != 3'd0) begin
				exp_pix <= {prio[1], sh_attr[1], dot[1]};
			end else begin
				exp_pix <= pix_in;
			end
			load[0] = load_a;
			load[1] = load_b;
			// shifters see the slots as they were before this edge
			for (int i = 0; i < 2; i++) begin
				if (load[i]) begin
					sh_attr[i] = slot_attr[i];
					sh_gfx[i]  = slot_gfx[i];
				end else begin
					sh_gfx[i] = (sh_gfx[i] << 1) & 12'heee;
				end
			end
			// a phase toggle ends a fetch
			// rising level means layer A
			if (fetch_phase != phase_seen) begin
				slot_attr[fetch_phase ? 0 : 1] = mdi;
				slot_gfx[fetch_phase ? 0 : 1]  = gdi;
			end
			phase_seen = fetch_phase;
			// priority sits in mdi bits 3 to 1
			if (prio_we && ca == 3'd1) prio[0] = mdi[3:1];
			if (prio_we && ca == 3'd5) prio[1] = mdi[3:1];
		end
	end

endmodule

`default_nettype wire

// File: test/tile_layer_tb.sv
`default_nettype none

module tile_layer_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD    = 40;
	localparam int SHIFT_ROUNDS  = 24;
	localparam int TRANSP_CYCLES = 16;
	localparam int PRIO_ROUNDS   = 32;
	localparam int SOAK_CYCLES   = 3000;
	// reset and directed steps, then each phase
	localparam int TOTAL_CYCLES  = 40 + SHIFT_ROUNDS * 8 + TRANSP_CYCLES + PRIO_ROUNDS * 11
		+ SOAK_CYCLES;

	logic        CLK_6M;
	logic        layer;
	logic        fetch_phase;
	logic [11:0] gdi;
	logic [7:0]  mdi;
	logic        load_a;
	logic        load_b;
	logic        prio_we;
	logic [2:0]  ca;
	logic [13:0] pix_in;
	wire  [13:0] pix_out;
	wire  [13:0] exp_pix;
	logic        check_en;

	tile_layer_gen dut (
		.CLK_6M      (CLK_6M),
		.layer       (layer),
		.fetch_phase (fetch_phase),
		.gdi         (gdi),
		.mdi         (mdi),
		.load_a      (load_a),
		.load_b      (load_b),
		.prio_we     (prio_we),
		.ca          (ca),
		.pix_in      (pix_in),
		.pix_out     (pix_out)
	);

	tile_layer_model model (
		.CLK_6M      (CLK_6M),
		.layer       (layer),
		.fetch_phase (fetch_phase),
		.gdi         (gdi),
		.mdi         (mdi),
		.load_a      (load_a),
		.load_b      (load_b),
		.prio_we     (prio_we),
		.ca          (ca),
		.pix_in      (pix_in),
		.exp_pix     (exp_pix)
	);

	initial begin
		CLK_6M = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_6M = ~CLK_6M;
	end

	initial begin
		#((TOTAL_CYCLES + 200) * CLK_PERIOD);
		$display("timeout: the tests ran far longer than their cycle count");
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	// outputs settle well before the falling edge
	always @(negedge CLK_6M) begin
		if (check_en) begin
			assert (pix_out === exp_pix) else begin
				$display("MISMATCH time=%0t signal=pix_out dut=%h expected=%h",
					$time, pix_out, exp_pix);
				$display("CHECKS FAILED");
				$fatal(1, "pix_out mismatch");
			end
		end
	end

	////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////

	// one clock of inputs, upstream pixel always random
	task automatic drive_cycle(input logic ph, input logic [7:0] m, input logic [11:0] g,
		input logic la, input logic lb, input logic we, input logic [2:0] addr);
		logic [31:0] pix_r;
		pix_r = $urandom;
		@(posedge CLK_6M);
		fetch_phase <= ph;
		mdi         <= m;
		gdi         <= g;
		load_a      <= la;
		load_b      <= lb;
		prio_we     <= we;
		ca          <= addr;
		pix_in      <= pix_r[13:0];
	endtask

	// phase goes high for A then low for B
	task automatic fetch_pair(input logic [7:0] attr_a, input logic [11:0] gfx_a,
		input logic [7:0] attr_b, input logic [11:0] gfx_b);
		drive_cycle(1'b1, attr_a, gfx_a, 1'b0, 1'b0, 1'b0, 3'd0);
		drive_cycle(1'b0, attr_b, gfx_b, 1'b0, 1'b0, 1'b0, 3'd0);
	endtask

	task automatic load_then_idle(input int n);
		drive_cycle(1'b0, 8'h00, 12'h000, 1'b1, 1'b1, 1'b0, 3'd0);
		repeat (n) drive_cycle(1'b0, 8'h00, 12'h000, 1'b0, 1'b0, 1'b0, 3'd0);
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		logic [31:0] r;
		logic [31:0] s;
		void'($urandom(32'h578bc287));
		check_en    = 1'b0;
		layer       = 1'b0;
		fetch_phase = 1'b0;
		gdi         = '0;
		mdi         = '0;
		load_a      = 1'b0;
		load_b      = 1'b0;
		prio_we     = 1'b0;
		ca          = '0;
		pix_in      = '0;
		repeat (4) @(posedge CLK_6M);
		layer    <= 1'b1;
		check_en <= 1'b1;

		// reset priorities, B at 1 beats A at 0
		fetch_pair(8'h3c, 12'hfff, 8'hc3, 12'hfff);
		load_then_idle(5);

		// random fetch then four dots msb first
		repeat (SHIFT_ROUNDS) begin
			r = $urandom;
			s = $urandom;
			fetch_pair(r[7:0], s[11:0], r[15:8], s[23:12]);
			load_then_idle(5);
		end

		// empty planes let the upstream pixel through
		r = $urandom;
		fetch_pair(r[7:0], 12'h000, r[15:8], 12'h000);
		load_then_idle(TRANSP_CYCLES);

		// priority writes, every fourth round a tie
		for (int n = 0; n < PRIO_ROUNDS; n++) begin
			r = $urandom;
			s = $urandom;
			drive_cycle(1'b0, r[7:0], 12'h000, 1'b0, 1'b0, 1'b1, 3'd1);
			drive_cycle(1'b0, (n % 4 == 0) ? r[7:0] : r[15:8], 12'h000,
				1'b0, 1'b0, 1'b1, 3'd5);
			drive_cycle(1'b0, r[23:16], 12'h000, 1'b0, 1'b0, 1'b1, r[26:24]);
			fetch_pair(s[7:0], s[19:8] | 12'h008, s[15:8], s[31:20] | 12'h008);
			load_then_idle(5);
		end

		// soak with everything random at once
		repeat (SOAK_CYCLES) begin
			r = $urandom;
			s = $urandom;
			drive_cycle(r[0], r[8:1], s[11:0], r[9] & r[10], r[11] & r[12],
				r[13] & r[14], r[17:15]);
		end

		repeat (2) @(posedge CLK_6M);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
logic/tile_video_pkg.sv
logic/tile_regs_pkg.sv
logic/tile_fetch_latch.sv
logic/tile_plane_shifter.sv
logic/tile_layer_mixer.sv
logic/tile_layer_gen.sv
test/tile_layer_model.sv
test/tile_layer_tb.sv

// File: Bender.yml
package:
  name: tile_layer_gen

sources:
  - logic/tile_video_pkg.sv
  - logic/tile_regs_pkg.sv
  - logic/tile_fetch_latch.sv
  - logic/tile_plane_shifter.sv
  - logic/tile_layer_mixer.sv
  - logic/tile_layer_gen.sv
  - target: test
    files:
      - test/tile_layer_model.sv
      - test/tile_layer_tb.sv
